/* all.f */
rtl/mini_mcu_pkg.sv
rtl/instr_decode.sv
rtl/alu_execute.sv
rtl/mini_core.sv
rtl/system_bus.sv
rtl/memory_subsystem.sv
rtl/peripheral_subsystem.sv
rtl/core_v_mini_mcu.sv
bench/mini_mcu_properties.sv
bench/tb_mini_mcu.sv

/* run.sh */
#!/bin/sh
# build the mini MCU testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f all.f --top-module tb_mini_mcu
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_mini_mcu 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx 'STATUS: PASS'; then
  exit 0
fi
echo "simulation did not report a pass"
exit 1

/* bench/tb_mini_mcu.sv */
/* mini MCU testbench
   loads programs through the external port and checks directed tests */
`timescale 1ns/1ps
`default_nettype none

module tb_mini_mcu
  import mini_mcu_pkg::*;
();

  localparam logic [31:0] BOOT_ADDR  = 32'h0000_0040;
  localparam logic [31:0] DATA_ADDR  = 32'h0000_0200;
  localparam logic [31:0] UNMAPPED   = 32'h0002_0000;
  localparam int          BUS_LIMIT  = 100;
  localparam int          EXIT_LIMIT = 5000;

  logic        clk_i, rst_n_i, fetch_enable_i;
  logic        ext_req_i, ext_we_i;
  logic [31:0] ext_addr_i, ext_wdata_i;
  logic        ext_gnt_o, ext_rvalid_o, exit_valid_o;
  logic [31:0] ext_rdata_o, exit_value_o;
  logic [31:0] prog [$];
  logic [31:0] last_exit;

  core_v_mini_mcu dut0 (
    .clk_i, .rst_n_i, .fetch_enable_i,
    .ext_req_i, .ext_addr_i, .ext_we_i, .ext_wdata_i,
    .ext_gnt_o, .ext_rvalid_o, .ext_rdata_o,
    .exit_value_o, .exit_valid_o
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic check_equal(input string test, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("error: %s expected %08h actual %08h", test, expected, actual));
    end
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    rst_n_i        <= 1'b0;
    fetch_enable_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
  endtask

  // one external transaction with outputs sampled on the falling edge
  task automatic bus_access(input logic we, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    @(posedge clk_i);
    ext_req_i   <= 1'b1;
    ext_we_i    <= we;
    ext_addr_i  <= addr;
    ext_wdata_i <= wdata;
    waited = 0;
    @(negedge clk_i);
    while (!ext_gnt_o) begin
      waited++;
      if (waited > BUS_LIMIT) abort_run("external port was never granted");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    ext_req_i <= 1'b0;
    ext_we_i  <= 1'b0;
    waited = 0;
    @(negedge clk_i);
    while (!ext_rvalid_o) begin
      waited++;
      if (waited > BUS_LIMIT) abort_run("external port got no response");
      @(negedge clk_i);
    end
    rdata = ext_rdata_o;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata);
    logic [31:0] ignored;
    bus_access(1'b1, addr, wdata, ignored);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
    bus_access(1'b0, addr, 32'h0, rdata);
  endtask

  function automatic logic [31:0] encode(input opcode_e op, input logic [1:0] rd,
                                         input logic [1:0] rs, input logic [15:0] imm);
    return {op, rd, rs, 8'h00, imm};
  endfunction

  // point base at PERIPH_BASE and store src at base + offset
  task automatic append_periph_store(input logic [1:0] src, input logic [1:0] base,
                                     input logic [15:0] offset);
    prog.push_back(encode(OP_LDI, base, 2'd0, 16'h8000));
    prog.push_back(encode(OP_ADD, base, base, 16'h0000));
    prog.push_back(encode(OP_ST, src, base, offset));
  endtask

  task automatic load_and_start();
    foreach (prog[i]) bus_write(BOOT_ADDR + 32'(4 * i), prog[i]);
    @(posedge clk_i);
    fetch_enable_i <= 1'b1;
  endtask

  task automatic wait_exit(input string test);
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (!exit_valid_o) begin
      waited++;
      if (waited > EXIT_LIMIT) abort_run({test, ": exit_valid_o never rose"});
      @(negedge clk_i);
    end
  endtask

  task automatic test_idle_memory();
    logic [31:0] exp_mem [256];
    logic [7:0]  idx_q [$];
    logic [7:0]  idx;
    logic [31:0] value;
    logic [31:0] rdata;
    for (int i = 0; i < 20; i++) begin
      idx   = 8'($urandom_range(255, 0));
      value = $urandom;
      exp_mem[idx] = value;
      idx_q.push_back(idx);
      bus_write({22'h0, idx, 2'b00}, value);
    end
    foreach (idx_q[i]) begin
      bus_read({22'h0, idx_q[i], 2'b00}, rdata);
      check_equal("idle_memory", exp_mem[idx_q[i]], rdata);
    end
    bus_write(UNMAPPED, 32'hdead_beef);
    bus_read(UNMAPPED, rdata);
    check_equal("unmapped_read", 32'h0, rdata);
    check_equal("idle_exit_valid", 32'h0, 32'(exit_valid_o));
  endtask

  task automatic test_arithmetic();
    logic [15:0] a, b, c, d;
    logic [31:0] r0, r3;
    a = 16'($urandom);
    b = 16'($urandom);
    c = 16'($urandom);
    d = 16'($urandom);
    r0 = 32'(a) + 32'(b);
    r0 = r0 - 32'(c);
    r3 = 32'(d) & r0;
    r0 = r0 ^ r3;
    apply_reset();
    prog = {};
    prog.push_back(encode(OP_LDI, 2'd0, 2'd0, a));
    prog.push_back(encode(OP_LDI, 2'd1, 2'd0, b));
    prog.push_back(encode(OP_ADD, 2'd0, 2'd1, 16'h0));
    prog.push_back(encode(OP_LDI, 2'd2, 2'd0, c));
    prog.push_back(encode(OP_SUB, 2'd0, 2'd2, 16'h0));
    prog.push_back(encode(OP_LDI, 2'd3, 2'd0, d));
    prog.push_back(encode(OP_AND, 2'd3, 2'd0, 16'h0));
    prog.push_back(encode(OP_XOR, 2'd0, 2'd3, 16'h0));
    append_periph_store(2'd0, 2'd1, EXIT_OFFSET[15:0]);
    prog.push_back(encode(OP_HALT, 2'd0, 2'd0, 16'h0));
    load_and_start();
    wait_exit("arithmetic");
    check_equal("arithmetic", r0, exit_value_o);
  endtask

  task automatic test_core_memory();
    logic [15:0] v0, v1;
    logic [31:0] rdata;
    v0 = 16'($urandom);
    v1 = 16'($urandom);
    apply_reset();
    prog = {};
    prog.push_back(encode(OP_LDI, 2'd0, 2'd0, v0));
    prog.push_back(encode(OP_LDI, 2'd1, 2'd0, v1));
    prog.push_back(encode(OP_LDI, 2'd2, 2'd0, DATA_ADDR[15:0]));
    prog.push_back(encode(OP_ST, 2'd0, 2'd2, 16'h0));
    prog.push_back(encode(OP_ST, 2'd1, 2'd2, 16'h4));
    prog.push_back(encode(OP_LD, 2'd3, 2'd2, 16'h0));
    prog.push_back(encode(OP_LD, 2'd0, 2'd2, 16'h4));
    prog.push_back(encode(OP_ADD, 2'd3, 2'd0, 16'h0));
    append_periph_store(2'd3, 2'd1, EXIT_OFFSET[15:0]);
    prog.push_back(encode(OP_HALT, 2'd0, 2'd0, 16'h0));
    load_and_start();
    wait_exit("core_memory");
    check_equal("core_memory_sum", 32'(v0) + 32'(v1), exit_value_o);
    bus_read(DATA_ADDR, rdata);
    check_equal("core_memory_word0", 32'(v0), rdata);
    bus_read(DATA_ADDR + 32'd4, rdata);
    check_equal("core_memory_word1", 32'(v1), rdata);
  endtask

  task automatic test_branch_loop();
    logic [15:0] n;
    n = 16'($urandom_range(20, 1));
    last_exit = 32'(n) * (32'(n) + 32'd1) / 32'd2;
    apply_reset();
    prog = {};
    prog.push_back(encode(OP_LDI, 2'd0, 2'd0, n));
    prog.push_back(encode(OP_LDI, 2'd1, 2'd0, 16'h0));
    prog.push_back(encode(OP_LDI, 2'd2, 2'd0, 16'h1));
    // loop body starts at the fourth word
    prog.push_back(encode(OP_ADD, 2'd1, 2'd0, 16'h0));
    prog.push_back(encode(OP_SUB, 2'd0, 2'd2, 16'h0));
    prog.push_back(encode(OP_BNZ, 2'd0, 2'd0, BOOT_ADDR[15:0] + 16'd12));
    append_periph_store(2'd1, 2'd3, EXIT_OFFSET[15:0]);
    prog.push_back(encode(OP_HALT, 2'd0, 2'd0, 16'h0));
    load_and_start();
    wait_exit("branch_loop");
    check_equal("branch_loop", last_exit, exit_value_o);
  endtask

  task automatic test_periph_and_halt();
    logic [31:0] scratch_val;
    logic [31:0] rdata;
    logic [15:0] prog_val;
    scratch_val = $urandom | 32'h8000_0000;
    bus_write(PERIPH_BASE + SCRATCH_OFFSET, scratch_val);
    bus_read(PERIPH_BASE + SCRATCH_OFFSET, rdata);
    check_equal("scratch_rw", scratch_val, rdata);
    bus_read(PERIPH_BASE + EXIT_OFFSET, rdata);
    check_equal("exit_read", last_exit, rdata);
    check_equal("exit_value_o", last_exit, exit_value_o);
    prog_val = 16'($urandom);
    apply_reset();
    prog = {};
    prog.push_back(encode(OP_LDI, 2'd0, 2'd0, prog_val));
    append_periph_store(2'd0, 2'd1, SCRATCH_OFFSET[15:0]);
    prog.push_back({4'd9, 28'h0});
    // never reached once the core halts
    append_periph_store(2'd0, 2'd1, EXIT_OFFSET[15:0]);
    load_and_start();
    repeat (200) @(posedge clk_i);
    @(negedge clk_i);
    check_equal("halt_exit_valid", 32'h0, 32'(exit_valid_o));
    bus_read(PERIPH_BASE + SCRATCH_OFFSET, rdata);
    check_equal("halt_scratch", 32'(prog_val), rdata);
  endtask

  initial begin
    rst_n_i        = 1'b0;
    fetch_enable_i = 1'b0;
    ext_req_i      = 1'b0;
    ext_we_i       = 1'b0;
    ext_addr_i     = '0;
    ext_wdata_i    = '0;
    last_exit      = '0;
    void'($urandom(39));
    apply_reset();
    test_idle_memory();
    test_arithmetic();
    test_core_memory();
    test_branch_loop();
    test_periph_and_halt();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/mini_mcu_properties.sv */
/* mini MCU protocol checks
   request stability, external response timing and sticky exit flag */
`timescale 1ns/1ps
`default_nettype none

module mini_mcu_properties (
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        instr_req_i,
  input logic [31:0] instr_addr_i,
  input logic        instr_gnt_i,
  input logic        data_req_i,
  input logic [31:0] data_addr_i,
  input logic        data_gnt_i,
  input logic        ext_gnt_i,
  input logic        ext_rvalid_i,
  input logic        exit_valid_i
);

  // pending requests hold until granted
  instr_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    instr_req_i && !instr_gnt_i |=> instr_req_i && $stable(instr_addr_i))
    else $error("instruction request dropped or changed before grant");

  data_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    data_req_i && !data_gnt_i |=> data_req_i && $stable(data_addr_i))
    else $error("data request dropped or changed before grant");

  ext_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ext_gnt_i |=> ext_rvalid_i)
    else $error("external grant without response one cycle later");

  ext_no_stray: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ext_rvalid_i |-> $past(ext_gnt_i))
    else $error("external response without a grant in the cycle before");

  // exit flag is sticky until reset
  exit_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    exit_valid_i |=> exit_valid_i)
    else $error("exit_valid_o fell outside reset");

endmodule

bind core_v_mini_mcu mini_mcu_properties mini_mcu_properties_i (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .instr_req_i (instr_req),
  .instr_addr_i(instr_addr),
  .instr_gnt_i (instr_gnt),
  .data_req_i  (data_req),
  .data_addr_i (data_addr),
  .data_gnt_i  (data_gnt),
  .ext_gnt_i   (ext_gnt_o),
  .ext_rvalid_i(ext_rvalid_o),
  .exit_valid_i(exit_valid_o)
);

`default_nettype wire

/* rtl/core_v_mini_mcu.sv */
/* mini MCU top level
   connects the core, system bus, RAM and peripheral block */
`timescale 1ns/1ps
`default_nettype none

module core_v_mini_mcu #(
  parameter int unsigned MEM_WORDS = 256,
  parameter logic [31:0] BOOT_ADDR = 32'h0000_0040
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        fetch_enable_i,

  input  logic        ext_req_i,
  input  logic [31:0] ext_addr_i,
  input  logic        ext_we_i,
  input  logic [31:0] ext_wdata_i,
  output logic        ext_gnt_o,
  output logic        ext_rvalid_o,
  output logic [31:0] ext_rdata_o,

  output logic [31:0] exit_value_o,
  output logic        exit_valid_o
);

  // core instruction port to RAM
  logic        instr_req, instr_gnt, instr_rvalid;
  logic [31:0] instr_addr, instr_rdata;

  // core data port to bus
  logic        data_req, data_we, data_gnt, data_rvalid;
  logic [31:0] data_addr, data_wdata, data_rdata;

  // bus to RAM and peripherals
  logic        ram_req, ram_we, ram_gnt, ram_rvalid;
  logic [31:0] ram_addr, ram_wdata, ram_rdata;
  logic        per_req, per_we, per_gnt, per_rvalid;
  logic [31:0] per_addr, per_wdata, per_rdata;

  mini_core #(
    .BOOT_ADDR(BOOT_ADDR)
  ) mini_core_i (
    .clk_i, .rst_n_i, .fetch_enable_i,
    .instr_req_o(instr_req), .instr_addr_o(instr_addr), .instr_gnt_i(instr_gnt),
    .instr_rvalid_i(instr_rvalid), .instr_rdata_i(instr_rdata),
    .data_req_o(data_req), .data_addr_o(data_addr), .data_we_o(data_we),
    .data_wdata_o(data_wdata), .data_gnt_i(data_gnt),
    .data_rvalid_i(data_rvalid), .data_rdata_i(data_rdata)
  );

  system_bus #(
    .MEM_WORDS(MEM_WORDS)
  ) system_bus_i (
    .clk_i, .rst_n_i,
    .data_req_i(data_req), .data_addr_i(data_addr), .data_we_i(data_we),
    .data_wdata_i(data_wdata), .data_gnt_o(data_gnt),
    .data_rvalid_o(data_rvalid), .data_rdata_o(data_rdata),
    .ext_req_i, .ext_addr_i, .ext_we_i, .ext_wdata_i,
    .ext_gnt_o, .ext_rvalid_o, .ext_rdata_o,
    .ram_req_o(ram_req), .ram_addr_o(ram_addr), .ram_we_o(ram_we),
    .ram_wdata_o(ram_wdata), .ram_gnt_i(ram_gnt),
    .ram_rvalid_i(ram_rvalid), .ram_rdata_i(ram_rdata),
    .per_req_o(per_req), .per_addr_o(per_addr), .per_we_o(per_we),
    .per_wdata_o(per_wdata), .per_gnt_i(per_gnt),
    .per_rvalid_i(per_rvalid), .per_rdata_i(per_rdata)
  );

  memory_subsystem #(
    .MEM_WORDS(MEM_WORDS)
  ) memory_subsystem_i (
    .clk_i, .rst_n_i,
    .instr_req_i(instr_req), .instr_addr_i(instr_addr), .instr_gnt_o(instr_gnt),
    .instr_rvalid_o(instr_rvalid), .instr_rdata_o(instr_rdata),
    .ram_req_i(ram_req), .ram_addr_i(ram_addr), .ram_we_i(ram_we),
    .ram_wdata_i(ram_wdata), .ram_gnt_o(ram_gnt),
    .ram_rvalid_o(ram_rvalid), .ram_rdata_o(ram_rdata)
  );

  peripheral_subsystem peripheral_subsystem_i (
    .clk_i, .rst_n_i,
    .per_req_i(per_req), .per_addr_i(per_addr), .per_we_i(per_we),
    .per_wdata_i(per_wdata), .per_gnt_o(per_gnt),
    .per_rvalid_o(per_rvalid), .per_rdata_o(per_rdata),
    .exit_value_o, .exit_valid_o
  );

endmodule

`default_nettype wire

/* rtl/peripheral_subsystem.sv */
/* peripheral block
   exit register with sticky valid flag, plus a scratch register */
`timescale 1ns/1ps
`default_nettype none

module peripheral_subsystem
  import mini_mcu_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,

  input  logic        per_req_i,
  input  logic [31:0] per_addr_i,
  input  logic        per_we_i,
  input  logic [31:0] per_wdata_i,
  output logic        per_gnt_o,
  output logic        per_rvalid_o,
  output logic [31:0] per_rdata_o,

  output logic [31:0] exit_value_o,
  output logic        exit_valid_o
);

  logic [2:0]  offset;
  logic        sel_exit, sel_scratch;
  logic [31:0] scratch_q;

  // word offset inside the peripheral window
  assign offset      = {per_addr_i[2], 2'b00};
  assign sel_exit    = (offset == EXIT_OFFSET[2:0]);
  assign sel_scratch = (offset == SCRATCH_OFFSET[2:0]);

  assign per_gnt_o = per_req_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_value_o <= '0;
      exit_valid_o <= 1'b0;
      per_rvalid_o <= 1'b0;
    end else begin
      per_rvalid_o <= per_req_i;
      if (per_req_i && per_we_i && sel_exit) begin
        exit_value_o <= per_wdata_i;
        exit_valid_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (per_req_i && per_we_i && sel_scratch) scratch_q <= per_wdata_i;
    if (per_req_i) per_rdata_o <= sel_exit ? exit_value_o : scratch_q;
  end

endmodule

`default_nettype wire

/* rtl/memory_subsystem.sv */
/* dual-ported word RAM
   read-only instruction port and read/write data port, one cycle latency */
`timescale 1ns/1ps
`default_nettype none

module memory_subsystem #(
  parameter int unsigned MEM_WORDS = 256
) (
  input  logic        clk_i,
  input  logic        rst_n_i,

  input  logic        instr_req_i,
  input  logic [31:0] instr_addr_i,
  output logic        instr_gnt_o,
  output logic        instr_rvalid_o,
  output logic [31:0] instr_rdata_o,

  input  logic        ram_req_i,
  input  logic [31:0] ram_addr_i,
  input  logic        ram_we_i,
  input  logic [31:0] ram_wdata_i,
  output logic        ram_gnt_o,
  output logic        ram_rvalid_o,
  output logic [31:0] ram_rdata_o
);

  localparam int unsigned AW = $clog2(MEM_WORDS);

  logic [31:0]   mem [MEM_WORDS];
  logic [AW-1:0] instr_idx, ram_idx;

  assign instr_idx = instr_addr_i[AW+1:2];
  assign ram_idx   = ram_addr_i[AW+1:2];

  // no back-pressure
  assign instr_gnt_o = instr_req_i;
  assign ram_gnt_o   = ram_req_i;

  // same-cycle collisions read the old word on both ports
  always_ff @(posedge clk_i) begin
    if (ram_req_i) begin
      ram_rdata_o <= mem[ram_idx];
      if (ram_we_i) mem[ram_idx] <= ram_wdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_req_i) instr_rdata_o <= mem[instr_idx];
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      instr_rvalid_o <= 1'b0;
      ram_rvalid_o   <= 1'b0;
    end else begin
      instr_rvalid_o <= instr_req_i;
      ram_rvalid_o   <= ram_req_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/system_bus.sv */
/* system bus
   fixed-priority arbiter, address decoder and response routing */
`timescale 1ns/1ps
`default_nettype none

module system_bus
  import mini_mcu_pkg::*;
#(
  parameter int unsigned MEM_WORDS = 256
) (
  input  logic        clk_i,
  input  logic        rst_n_i,

  input  logic        data_req_i,
  input  logic [31:0] data_addr_i,
  input  logic        data_we_i,
  input  logic [31:0] data_wdata_i,
  output logic        data_gnt_o,
  output logic        data_rvalid_o,
  output logic [31:0] data_rdata_o,

  input  logic        ext_req_i,
  input  logic [31:0] ext_addr_i,
  input  logic        ext_we_i,
  input  logic [31:0] ext_wdata_i,
  output logic        ext_gnt_o,
  output logic        ext_rvalid_o,
  output logic [31:0] ext_rdata_o,

  output logic        ram_req_o,
  output logic [31:0] ram_addr_o,
  output logic        ram_we_o,
  output logic [31:0] ram_wdata_o,
  input  logic        ram_gnt_i,
  input  logic        ram_rvalid_i,
  input  logic [31:0] ram_rdata_i,

  output logic        per_req_o,
  output logic [31:0] per_addr_o,
  output logic        per_we_o,
  output logic [31:0] per_wdata_o,
  input  logic        per_gnt_i,
  input  logic        per_rvalid_i,
  input  logic [31:0] per_rdata_i
);

  localparam logic [31:0] RAM_BYTES = 32'(4 * MEM_WORDS);

  logic        bus_req, bus_we, hit_ram, hit_per, tgt_gnt, granted;
  logic [31:0] bus_addr, bus_wdata;
  logic        resp_ram_q, resp_per_q, resp_miss_q, resp_ext_q;
  logic        resp_valid;
  logic [31:0] resp_rdata;

  // core data port always wins
  assign bus_req   = data_req_i | ext_req_i;
  assign bus_addr  = data_req_i ? data_addr_i : ext_addr_i;
  assign bus_we    = data_req_i ? data_we_i : ext_we_i;
  assign bus_wdata = data_req_i ? data_wdata_i : ext_wdata_i;

  assign hit_ram = (bus_addr - RAM_BASE) < RAM_BYTES;
  assign hit_per = (bus_addr[31:3] == PERIPH_BASE[31:3]);

  assign ram_req_o   = bus_req & hit_ram;
  assign ram_addr_o  = bus_addr;
  assign ram_we_o    = bus_we;
  assign ram_wdata_o = bus_wdata;

  assign per_req_o   = bus_req & hit_per;
  assign per_addr_o  = bus_addr;
  assign per_we_o    = bus_we;
  assign per_wdata_o = bus_wdata;

  // unmapped accesses are accepted immediately
  assign tgt_gnt = hit_ram ? ram_gnt_i : (hit_per ? per_gnt_i : 1'b1);
  assign granted = bus_req & tgt_gnt;

  assign data_gnt_o = data_req_i & tgt_gnt;
  assign ext_gnt_o  = ~data_req_i & ext_req_i & tgt_gnt;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      resp_ram_q  <= 1'b0;
      resp_per_q  <= 1'b0;
      resp_miss_q <= 1'b0;
      resp_ext_q  <= 1'b0;
    end else begin
      resp_ram_q  <= granted & hit_ram;
      resp_per_q  <= granted & hit_per;
      resp_miss_q <= granted & ~hit_ram & ~hit_per;
      resp_ext_q  <= ~data_req_i;
    end
  end

  assign resp_valid = (resp_ram_q & ram_rvalid_i) | (resp_per_q & per_rvalid_i) | resp_miss_q;
  assign resp_rdata = resp_ram_q ? ram_rdata_i : (resp_per_q ? per_rdata_i : '0);

  assign data_rvalid_o = resp_valid & ~resp_ext_q;
  assign ext_rvalid_o  = resp_valid & resp_ext_q;
  assign data_rdata_o  = resp_rdata;
  assign ext_rdata_o   = resp_rdata;

endmodule

`default_nettype wire

/* rtl/mini_core.sv */
/* small 32-bit load/store core
   state machine, register file and pc with instruction and data bus ports */
`timescale 1ns/1ps
`default_nettype none

module mini_core
  import mini_mcu_pkg::*;
#(
  parameter logic [31:0] BOOT_ADDR = 32'h0000_0040
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        fetch_enable_i,

  output logic        instr_req_o,
  output logic [31:0] instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  logic [31:0] instr_rdata_i,

  output logic        data_req_o,
  output logic [31:0] data_addr_o,
  output logic        data_we_o,
  output logic [31:0] data_wdata_o,
  input  logic        data_gnt_i,
  input  logic        data_rvalid_i,
  input  logic [31:0] data_rdata_i
);

  core_state_e state_q, state_d;
  logic [31:0] pc_q;
  logic [31:0] ir_q;
  logic [31:0] rf_q [4];

  opcode_e     opcode;
  logic [1:0]  rd_idx, rs_idx;
  logic [31:0] imm;
  logic        is_mem, is_store, is_branch, is_halt;
  logic [31:0] rd_val, rs_val;
  logic [31:0] alu_result, mem_addr;
  logic        branch_taken;

  logic        rf_we;
  logic [31:0] rf_wdata;
  logic        pc_en;
  logic [31:0] pc_next;

  instr_decode instr_decode_i (
    .instr_i    (ir_q),
    .opcode_o   (opcode),
    .rd_o       (rd_idx),
    .rs_o       (rs_idx),
    .imm_o      (imm),
    .is_mem_o   (is_mem),
    .is_store_o (is_store),
    .is_branch_o(is_branch),
    .is_halt_o  (is_halt)
  );

  assign rd_val = rf_q[rd_idx];
  assign rs_val = rf_q[rs_idx];

  alu_execute alu_execute_i (
    .opcode_i      (opcode),
    .rd_val_i      (rd_val),
    .rs_val_i      (rs_val),
    .imm_i         (imm),
    .result_o      (alu_result),
    .mem_addr_o    (mem_addr),
    .branch_taken_o(branch_taken)
  );

  always_comb begin
    state_d = state_q;
    case (state_q)
      CS_IDLE:  if (fetch_enable_i) state_d = CS_FETCH;
      CS_FETCH: if (instr_gnt_i) state_d = CS_FWAIT;
      CS_FWAIT: if (instr_rvalid_i) state_d = CS_EXEC;
      CS_EXEC: begin
        if (is_halt) state_d = CS_HALT;
        else if (is_mem) state_d = CS_MEM;
        else state_d = CS_FETCH;
      end
      CS_MEM:   if (data_gnt_i) state_d = CS_MWAIT;
      CS_MWAIT: if (data_rvalid_i) state_d = CS_FETCH;
      default:  state_d = CS_HALT;
    endcase
  end

  // result write-back and pc update
  always_comb begin
    rf_we    = 1'b0;
    rf_wdata = alu_result;
    pc_en    = 1'b0;
    pc_next  = pc_q + 32'd4;
    if (state_q == CS_EXEC && !is_halt && !is_mem) begin
      rf_we = !is_branch;
      pc_en = 1'b1;
      if (is_branch && branch_taken) pc_next = imm;
    end else if (state_q == CS_MWAIT && data_rvalid_i) begin
      rf_we    = !is_store;
      rf_wdata = data_rdata_i;
      pc_en    = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= CS_IDLE;
      pc_q    <= BOOT_ADDR;
      for (int i = 0; i < 4; i++) begin
        rf_q[i] <= '0;
      end
    end else begin
      state_q <= state_d;
      if (pc_en) pc_q <= pc_next;
      if (rf_we) rf_q[rd_idx] <= rf_wdata;
    end
  end

  // instruction register
  always_ff @(posedge clk_i) begin
    if (state_q == CS_FWAIT && instr_rvalid_i) ir_q <= instr_rdata_i;
  end

  assign instr_req_o  = (state_q == CS_FETCH);
  assign instr_addr_o = pc_q;

  assign data_req_o   = (state_q == CS_MEM);
  assign data_addr_o  = mem_addr;
  assign data_we_o    = is_store;
  assign data_wdata_o = rd_val;

endmodule

`default_nettype wire

/* rtl/alu_execute.sv */
/* execute stage
   register arithmetic, load/store address and branch decision */
`timescale 1ns/1ps
`default_nettype none

module alu_execute
  import mini_mcu_pkg::*;
(
  input  opcode_e     opcode_i,
  input  logic [31:0] rd_val_i,
  input  logic [31:0] rs_val_i,
  input  logic [31:0] imm_i,
  output logic [31:0] result_o,
  output logic [31:0] mem_addr_o,
  output logic        branch_taken_o
);

  always_comb begin
    case (opcode_i)
      OP_LDI:  result_o = imm_i;
      OP_ADD:  result_o = rd_val_i + rs_val_i;
      OP_SUB:  result_o = rd_val_i - rs_val_i;
      OP_AND:  result_o = rd_val_i & rs_val_i;
      OP_XOR:  result_o = rd_val_i ^ rs_val_i;
      default: result_o = '0;
    endcase
  end

  // effective address for ld/st
  assign mem_addr_o = rs_val_i + imm_i;

  assign branch_taken_o = (rd_val_i != '0);

endmodule

`default_nettype wire

/* rtl/instr_decode.sv */
/* instruction decoder
   splits an instruction word into fields and classifies it */
`timescale 1ns/1ps
`default_nettype none

module instr_decode
  import mini_mcu_pkg::*;
(
  input  logic [31:0] instr_i,
  output opcode_e     opcode_o,
  output logic [1:0]  rd_o,
  output logic [1:0]  rs_o,
  output logic [31:0] imm_o,
  output logic        is_mem_o,
  output logic        is_store_o,
  output logic        is_branch_o,
  output logic        is_halt_o
);

  logic [3:0] opc_raw;

  assign opc_raw = instr_i[OPC_MSB:OPC_LSB];

  // unknown encodings stop the core
  always_comb begin
    case (opc_raw)
      OP_LDI, OP_ADD, OP_SUB, OP_AND, OP_XOR,
      OP_LD, OP_ST, OP_BNZ: opcode_o = opcode_e'(opc_raw);
      default:              opcode_o = OP_HALT;
    endcase
  end

  assign rd_o  = instr_i[RD_MSB:RD_LSB];
  assign rs_o  = instr_i[RS_MSB:RS_LSB];
  assign imm_o = 32'(instr_i[IMM_MSB:IMM_LSB]);

  assign is_mem_o    = (opcode_o == OP_LD) || (opcode_o == OP_ST);
  assign is_store_o  = (opcode_o == OP_ST);
  assign is_branch_o = (opcode_o == OP_BNZ);
  assign is_halt_o   = (opcode_o == OP_HALT);

endmodule

`default_nettype wire

/* rtl/mini_mcu_pkg.sv */
/* mini MCU shared definitions
   address map, instruction field layout, opcodes and core states */
`default_nettype none

package mini_mcu_pkg;

  // byte address map
  localparam logic [31:0] RAM_BASE       = 32'h0000_0000;
  localparam logic [31:0] PERIPH_BASE    = 32'h0001_0000;
  localparam logic [31:0] EXIT_OFFSET    = 32'h0000_0000;
  localparam logic [31:0] SCRATCH_OFFSET = 32'h0000_0004;

  // instruction fields with bits 23:16 unused
  localparam int unsigned OPC_MSB = 31;
  localparam int unsigned OPC_LSB = 28;
  localparam int unsigned RD_MSB  = 27;
  localparam int unsigned RD_LSB  = 26;
  localparam int unsigned RS_MSB  = 25;
  localparam int unsigned RS_LSB  = 24;
  localparam int unsigned IMM_MSB = 15;
  localparam int unsigned IMM_LSB = 0;

  typedef enum logic [3:0] {
    OP_LDI  = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_AND  = 4'd3,
    OP_XOR  = 4'd4,
    OP_LD   = 4'd5,
    OP_ST   = 4'd6,
    OP_BNZ  = 4'd7,
    OP_HALT = 4'd15
  } opcode_e;

  typedef enum logic [2:0] {
    CS_IDLE,
    CS_FETCH,
    CS_FWAIT,
    CS_EXEC,
    CS_MEM,
    CS_MWAIT,
    CS_HALT
  } core_state_e;

endpackage

`default_nettype wire
